// File: hdl/isa_pkg.sv
package isa_pkg;

	// Instruction opcodes, 6 bits
	typedef enum logic [5:0] {
		NOP   = 6'd0,  // Only advances the PC
		ADD   = 6'd1,
		ADDI  = 6'd2,
		SUB   = 6'd3,
		SUBI  = 6'd4,
		MUL   = 6'd5,
		MULI  = 6'd6,
		DIV   = 6'd7,
		DIVI  = 6'd8,
		AND   = 6'd9,
		ANDI  = 6'd10,
		OR    = 6'd11,
		ORI   = 6'd12,
		XOR   = 6'd13,
		XORI  = 6'd14,
		NOT   = 6'd15,
		SL    = 6'd16, // Shift left
		SR    = 6'd17, // Shift right
		MOV   = 6'd18,
		LW    = 6'd19, // Load word
		LI    = 6'd20, // Load immediate
		LA    = 6'd21, // Load address
		SW    = 6'd22, // Store word, address from immediate
		BEQ   = 6'd23,
		BNE   = 6'd24,
		BLT   = 6'd25,
		BLET  = 6'd26,
		BGT   = 6'd27,
		BGET  = 6'd28,
		J     = 6'd29,
		JAL   = 6'd30, // Jump and link
		JR    = 6'd31, // Jump to register
		IN    = 6'd32, // Waits for input ready
		OUT   = 6'd33, // Output strobe
		RESET = 6'd62, // Clears the PC
		HALT  = 6'd63  // Waits for the release key
	} opcode_t;

	// ALU operation select, 4 bits
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_MUL    = 4'd2,
		ALU_DIV    = 4'd3,
		ALU_AND    = 4'd4,
		ALU_OR     = 4'd5,
		ALU_XOR    = 4'd6,
		ALU_NOT    = 4'd7,  // Operand A only
		ALU_SHL    = 4'd8,
		ALU_SHR    = 4'd9,
		ALU_PASS_A = 4'd10, // Result is operand A
		ALU_PASS_B = 4'd11  // Result is operand B
	} alu_op_t;

endpackage

// File: hdl/control_pkg.sv
package control_pkg;

	// Register file destination field
	typedef enum logic [1:0] {
		DEST_RT   = 2'd0,
		DEST_RD   = 2'd1,
		DEST_LINK = 2'd2  // Link register for JAL
	} dest_sel_t;

	// ALU second operand
	typedef enum logic {
		SRC_REG = 1'b0,
		SRC_IMM = 1'b1
	} alu_src_t;

	// Register write-back source
	typedef enum logic [1:0] {
		WB_PC_NEXT = 2'd0,
		WB_ALU     = 2'd1,
		WB_MEMORY  = 2'd2,
		WB_INPUT   = 2'd3
	} wb_sel_t;

	// Next PC source
	typedef enum logic [1:0] {
		PC_HOLD   = 2'd0,
		PC_INCR   = 2'd1,
		PC_BRANCH = 2'd2,
		PC_JUMP   = 2'd3
	} pc_sel_t;

	// Why an instruction may stop the processor
	typedef enum logic [1:0] {
		STALL_NONE    = 2'd0,
		STALL_INPUT   = 2'd1,
		STALL_HALT    = 2'd2,
		STALL_RESTART = 2'd3
	} stall_class_t;

	// Control word, 16 bits
	typedef struct packed {
		dest_sel_t       dest_sel;
		alu_src_t        alu_src;
		wb_sel_t         wb_sel;
		pc_sel_t         pc_sel;
		isa_pkg::alu_op_t alu_op;
		logic            pc_write;
		logic            pc_clear;
		logic            reg_write;
		logic            mem_write;
		logic            out_strobe;
	} ctrl_word_t;

	localparam ctrl_word_t CTRL_IDLE = '0; // PC held, nothing written

endpackage

// File: hdl/opcode_decoder.sv
`timescale 1ns/1ps

module opcode_decoder (
	input  isa_pkg::opcode_t          opcode,
	output control_pkg::ctrl_word_t   decoded,
	output control_pkg::stall_class_t stall
);

	always_comb begin
		// Base word is a plain PC increment
		decoded          = control_pkg::CTRL_IDLE;
		decoded.pc_sel   = control_pkg::PC_INCR;
		decoded.pc_write = 1'b1;
		stall            = control_pkg::STALL_NONE;

		// ALU operation, add unless listed
		case (opcode)
			isa_pkg::SUB, isa_pkg::SUBI:
				decoded.alu_op = isa_pkg::ALU_SUB;
			isa_pkg::MUL, isa_pkg::MULI:
				decoded.alu_op = isa_pkg::ALU_MUL;
			isa_pkg::DIV, isa_pkg::DIVI:
				decoded.alu_op = isa_pkg::ALU_DIV;
			isa_pkg::AND, isa_pkg::ANDI:
				decoded.alu_op = isa_pkg::ALU_AND;
			isa_pkg::OR, isa_pkg::ORI:
				decoded.alu_op = isa_pkg::ALU_OR;
			isa_pkg::XOR, isa_pkg::XORI:
				decoded.alu_op = isa_pkg::ALU_XOR;
			isa_pkg::NOT:
				decoded.alu_op = isa_pkg::ALU_NOT;
			isa_pkg::SL:
				decoded.alu_op = isa_pkg::ALU_SHL;
			isa_pkg::SR:
				decoded.alu_op = isa_pkg::ALU_SHR;
			isa_pkg::MOV:
				decoded.alu_op = isa_pkg::ALU_PASS_A;
			isa_pkg::LI, isa_pkg::OUT, isa_pkg::JR,
			isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLT,
			isa_pkg::BLET, isa_pkg::BGT, isa_pkg::BGET:
				decoded.alu_op = isa_pkg::ALU_PASS_B; // Immediate or RT through
			default:
				decoded.alu_op = isa_pkg::ALU_ADD;    // Also address calc for LW, LA, SW
		endcase

		// Operand routing, write-back and enables
		case (opcode)
			isa_pkg::ADD, isa_pkg::SUB, isa_pkg::MUL, isa_pkg::DIV,
			isa_pkg::AND, isa_pkg::OR, isa_pkg::XOR, isa_pkg::SL, isa_pkg::SR: begin
				decoded.dest_sel  = control_pkg::DEST_RD; // Register form
				decoded.wb_sel    = control_pkg::WB_ALU;
				decoded.reg_write = 1'b1;
			end
			isa_pkg::ADDI, isa_pkg::SUBI, isa_pkg::MULI, isa_pkg::DIVI,
			isa_pkg::ANDI, isa_pkg::ORI, isa_pkg::XORI, isa_pkg::LI, isa_pkg::LA: begin
				decoded.alu_src   = control_pkg::SRC_IMM; // Immediate form into RT
				decoded.wb_sel    = control_pkg::WB_ALU;
				decoded.reg_write = 1'b1;
			end
			isa_pkg::NOT, isa_pkg::MOV: begin
				decoded.wb_sel    = control_pkg::WB_ALU;  // Single operand into RT
				decoded.reg_write = 1'b1;
			end
			isa_pkg::LW: begin
				decoded.alu_src   = control_pkg::SRC_IMM;
				decoded.wb_sel    = control_pkg::WB_MEMORY;
				decoded.reg_write = 1'b1;
			end
			isa_pkg::SW: begin
				decoded.alu_src   = control_pkg::SRC_IMM;
				decoded.mem_write = 1'b1;
			end
			isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLT,
			isa_pkg::BLET, isa_pkg::BGT, isa_pkg::BGET, isa_pkg::JR: begin
				decoded.pc_sel = control_pkg::PC_BRANCH; // Target taken from ALU
			end
			isa_pkg::J: begin
				decoded.pc_sel = control_pkg::PC_JUMP;
			end
			isa_pkg::JAL: begin
				decoded.dest_sel  = control_pkg::DEST_LINK;
				decoded.wb_sel    = control_pkg::WB_PC_NEXT; // Return address
				decoded.pc_sel    = control_pkg::PC_JUMP;
				decoded.reg_write = 1'b1;
			end
			isa_pkg::IN: begin
				// Word issued once the input is ready
				decoded.wb_sel    = control_pkg::WB_INPUT;
				decoded.reg_write = 1'b1;
				stall             = control_pkg::STALL_INPUT;
			end
			isa_pkg::OUT: begin
				decoded.alu_src    = control_pkg::SRC_IMM; // Output port address
				decoded.out_strobe = 1'b1;
			end
			isa_pkg::RESET: begin
				decoded = control_pkg::CTRL_IDLE;
				stall   = control_pkg::STALL_RESTART;
			end
			isa_pkg::HALT: begin
				decoded = control_pkg::CTRL_IDLE;
				stall   = control_pkg::STALL_HALT;
			end
			default: begin
				decoded.pc_sel = control_pkg::PC_INCR; // NOP and undefined opcodes
			end
		endcase
	end

endmodule

// File: hdl/run_state_fsm.sv
`timescale 1ns/1ps

module run_state_fsm (
	input  logic                      clock,
	input  logic                      reset,
	input  control_pkg::ctrl_word_t   decoded,
	input  control_pkg::stall_class_t stall,
	input  logic                      in_ready,     // Input data available
	input  logic                      halt_release, // Release key level
	output control_pkg::ctrl_word_t   ctrl
);

	typedef enum logic {
		RUNNING = 1'b0,
		STOPPED = 1'b1
	} run_state_t;

	run_state_t              state;
	control_pkg::ctrl_word_t restart_word;
	logic                    input_done;
	logic                    halt_done;

	always_comb begin
		restart_word          = control_pkg::CTRL_IDLE;
		restart_word.pc_clear = 1'b1; // Sends the PC back to zero
	end

	// Ways out of the stopped state
	assign input_done = (stall == control_pkg::STALL_INPUT) && in_ready;
	assign halt_done  = (stall == control_pkg::STALL_HALT) && halt_release;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= RUNNING;
			ctrl  <= control_pkg::CTRL_IDLE;
		end else if (stall == control_pkg::STALL_RESTART) begin
			state <= RUNNING; // Restart wins in either state
			ctrl  <= restart_word;
		end else if (state == RUNNING) begin
			if (stall == control_pkg::STALL_NONE) begin
				ctrl <= decoded;
			end else begin
				state <= STOPPED; // IN or HALT, PC held
				ctrl  <= control_pkg::CTRL_IDLE;
			end
		end else begin
			if (input_done) begin
				state <= RUNNING;
				ctrl  <= decoded; // IN completion word
			end else if (halt_done) begin
				state <= RUNNING;
				ctrl  <= restart_word;
			end
			// Otherwise keep waiting with ctrl unchanged
		end
	end

endmodule

// File: hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  logic                    clock,
	input  logic                    reset,
	input  isa_pkg::opcode_t        opcode,
	input  logic                    in_ready,
	input  logic                    halt_release,
	output control_pkg::ctrl_word_t ctrl
);

	control_pkg::ctrl_word_t   decoded;
	control_pkg::stall_class_t stall;

	opcode_decoder u_decoder (
		.opcode  (opcode),
		.decoded (decoded),
		.stall   (stall)
	);

	run_state_fsm u_state (
		.clock        (clock),
		.reset        (reset),
		.decoded      (decoded),
		.stall        (stall),
		.in_ready     (in_ready),
		.halt_release (halt_release),
		.ctrl         (ctrl)
	);

endmodule

// File: testbench/tb_expected.svh
`ifndef TB_EXPECTED_SVH
`define TB_EXPECTED_SVH

// Every executed word advances the PC through pc_write
function automatic control_pkg::ctrl_word_t make_word(
	input control_pkg::dest_sel_t dest,
	input control_pkg::alu_src_t  src,
	input control_pkg::wb_sel_t   wb,
	input control_pkg::pc_sel_t   pc,
	input isa_pkg::alu_op_t       alu,
	input logic                   reg_write,
	input logic                   mem_write,
	input logic                   out_strobe
);
	control_pkg::ctrl_word_t w;
	w.dest_sel   = dest;
	w.alu_src    = src;
	w.wb_sel     = wb;
	w.pc_sel     = pc;
	w.alu_op     = alu;
	w.pc_write   = 1'b1;
	w.pc_clear   = 1'b0;
	w.reg_write  = reg_write;
	w.mem_write  = mem_write;
	w.out_strobe = out_strobe;
	return w;
endfunction

function automatic control_pkg::ctrl_word_t reg_alu(input isa_pkg::alu_op_t alu);
	return make_word(control_pkg::DEST_RD, control_pkg::SRC_REG, control_pkg::WB_ALU,
		control_pkg::PC_INCR, alu, 1'b1, 1'b0, 1'b0);
endfunction

function automatic control_pkg::ctrl_word_t imm_alu(input isa_pkg::alu_op_t alu);
	return make_word(control_pkg::DEST_RT, control_pkg::SRC_IMM, control_pkg::WB_ALU,
		control_pkg::PC_INCR, alu, 1'b1, 1'b0, 1'b0);
endfunction

function automatic control_pkg::ctrl_word_t expected_word(input logic [5:0] op);
	case (op)
		isa_pkg::ADD:  return reg_alu(isa_pkg::ALU_ADD);
		isa_pkg::SUB:  return reg_alu(isa_pkg::ALU_SUB);
		isa_pkg::MUL:  return reg_alu(isa_pkg::ALU_MUL);
		isa_pkg::DIV:  return reg_alu(isa_pkg::ALU_DIV);
		isa_pkg::AND:  return reg_alu(isa_pkg::ALU_AND);
		isa_pkg::OR:   return reg_alu(isa_pkg::ALU_OR);
		isa_pkg::XOR:  return reg_alu(isa_pkg::ALU_XOR);
		isa_pkg::SL:   return reg_alu(isa_pkg::ALU_SHL);
		isa_pkg::SR:   return reg_alu(isa_pkg::ALU_SHR);
		isa_pkg::ADDI: return imm_alu(isa_pkg::ALU_ADD);
		isa_pkg::SUBI: return imm_alu(isa_pkg::ALU_SUB);
		isa_pkg::MULI: return imm_alu(isa_pkg::ALU_MUL);
		isa_pkg::DIVI: return imm_alu(isa_pkg::ALU_DIV);
		isa_pkg::ANDI: return imm_alu(isa_pkg::ALU_AND);
		isa_pkg::ORI:  return imm_alu(isa_pkg::ALU_OR);
		isa_pkg::XORI: return imm_alu(isa_pkg::ALU_XOR);
		isa_pkg::LI:   return imm_alu(isa_pkg::ALU_PASS_B); // Immediate passed through
		isa_pkg::LA:   return imm_alu(isa_pkg::ALU_ADD);
		isa_pkg::NOT:  return make_word(control_pkg::DEST_RT, control_pkg::SRC_REG,
			control_pkg::WB_ALU, control_pkg::PC_INCR, isa_pkg::ALU_NOT, 1'b1, 1'b0, 1'b0);
		isa_pkg::MOV:  return make_word(control_pkg::DEST_RT, control_pkg::SRC_REG,
			control_pkg::WB_ALU, control_pkg::PC_INCR, isa_pkg::ALU_PASS_A, 1'b1, 1'b0, 1'b0);
		isa_pkg::LW:   return make_word(control_pkg::DEST_RT, control_pkg::SRC_IMM,
			control_pkg::WB_MEMORY, control_pkg::PC_INCR, isa_pkg::ALU_ADD, 1'b1, 1'b0, 1'b0);
		isa_pkg::SW:   return make_word(control_pkg::DEST_RT, control_pkg::SRC_IMM,
			control_pkg::WB_PC_NEXT, control_pkg::PC_INCR, isa_pkg::ALU_ADD, 1'b0, 1'b1, 1'b0);
		isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BLT, isa_pkg::BLET, isa_pkg::BGT, isa_pkg::BGET,
		isa_pkg::JR:   return make_word(control_pkg::DEST_RT, control_pkg::SRC_REG,
			control_pkg::WB_PC_NEXT, control_pkg::PC_BRANCH, isa_pkg::ALU_PASS_B, 1'b0, 1'b0, 1'b0);
		isa_pkg::J:    return make_word(control_pkg::DEST_RT, control_pkg::SRC_REG,
			control_pkg::WB_PC_NEXT, control_pkg::PC_JUMP, isa_pkg::ALU_ADD, 1'b0, 1'b0, 1'b0);
		isa_pkg::JAL:  return make_word(control_pkg::DEST_LINK, control_pkg::SRC_REG,
			control_pkg::WB_PC_NEXT, control_pkg::PC_JUMP, isa_pkg::ALU_ADD, 1'b1, 1'b0, 1'b0);
		isa_pkg::IN:   return make_word(control_pkg::DEST_RT, control_pkg::SRC_REG,
			control_pkg::WB_INPUT, control_pkg::PC_INCR, isa_pkg::ALU_ADD, 1'b1, 1'b0, 1'b0);
		isa_pkg::OUT:  return make_word(control_pkg::DEST_RT, control_pkg::SRC_IMM,
			control_pkg::WB_PC_NEXT, control_pkg::PC_INCR, isa_pkg::ALU_PASS_B, 1'b0, 1'b0, 1'b1);
		isa_pkg::RESET, isa_pkg::HALT: return control_pkg::CTRL_IDLE;
		default:       return make_word(control_pkg::DEST_RT, control_pkg::SRC_REG,
			control_pkg::WB_PC_NEXT, control_pkg::PC_INCR, isa_pkg::ALU_ADD, 1'b0, 1'b0, 1'b0);
	endcase
endfunction

// Idle word plus the PC clear
function automatic control_pkg::ctrl_word_t expected_restart();
	control_pkg::ctrl_word_t w;
	w          = control_pkg::CTRL_IDLE;
	w.pc_clear = 1'b1;
	return w;
endfunction

function automatic logic is_defined(input logic [5:0] op);
	return (op <= 6'd33) || (op >= 6'd62);
endfunction

function automatic logic stalls_run(input logic [5:0] op);
	return (op == isa_pkg::IN) || (op == isa_pkg::RESET) || (op == isa_pkg::HALT);
endfunction

`endif

// File: testbench/tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit;

	logic                    clock;
	logic                    reset;
	isa_pkg::opcode_t        opcode;
	logic                    in_ready;
	logic                    halt_release;
	control_pkg::ctrl_word_t ctrl;

	int          errors;
	int          timeouts;
	logic [31:0] lfsr;

	`include "tb_expected.svh"

	control_unit dut (
		.clock        (clock),
		.reset        (reset),
		.opcode       (opcode),
		.in_ready     (in_ready),
		.halt_release (halt_release),
		.ctrl         (ctrl)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // x^32+x^22+x^2+x+1
	endfunction

	task automatic random_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr  = lfsr_step(lfsr);
		end
	endtask

	task automatic compare_value(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		if (actual !== expected) begin
			errors = errors + 1;
			$display("** Error at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// Polls at the falling edge until pc_clear or pc_write is seen
	task automatic wait_flag(input bit want_clear, input string name);
		int   cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < 10) begin
			@(negedge clock);
			seen   = want_clear ? ctrl.pc_clear : ctrl.pc_write;
			cycles = cycles + 1;
		end
		if (!seen) begin
			timeouts = timeouts + 1;
			$display("Timeout at %0d ns: ctrl.%s never rose within 10 cycles", $time, name);
		end
	endtask

	// Opcode present for one cycle, word checked one cycle later
	task automatic issue_opcode(input logic [5:0] op);
		@(posedge clock);
		opcode <= isa_pkg::opcode_t'(op);
		@(posedge clock);
		opcode <= isa_pkg::NOP;
		@(negedge clock);
		compare_value(ctrl, expected_word(op), $sformatf("word for opcode %0d", op));
	endtask

	task automatic after_reset_idle();
		@(negedge clock);
		compare_value(ctrl, control_pkg::CTRL_IDLE, "ctrl after reset");
	endtask

	task automatic defined_opcodes();
		for (int v = 0; v < 64; v++) begin
			if (is_defined(v[5:0]) && !stalls_run(v[5:0])) begin
				issue_opcode(v[5:0]);
			end
		end
	endtask

	task automatic undefined_opcodes();
		logic [31:0] v;
		for (int k = 0; k < 12; k++) begin
			random_bits(6, v);
			while (is_defined(v[5:0])) begin
				random_bits(6, v); // Redraw until outside the ISA
			end
			issue_opcode(v[5:0]);
		end
	endtask

	task automatic input_stall();
		logic [31:0] extra;
		random_bits(3, extra);
		@(posedge clock);
		opcode   <= isa_pkg::IN;
		in_ready <= 1'b0;
		@(posedge clock);
		repeat (2 + extra[2:0]) begin
			@(negedge clock);
			compare_value(ctrl, control_pkg::CTRL_IDLE, "ctrl while IN waits");
		end
		@(posedge clock);
		in_ready <= 1'b1;
		@(posedge clock);
		opcode   <= isa_pkg::NOP; // PC moves on after this edge
		in_ready <= 1'b0;
		wait_flag(1'b0, "pc_write");
		compare_value(ctrl, expected_word(isa_pkg::IN), "IN completion word");
	endtask

	task automatic halt_release_restart();
		@(posedge clock);
		opcode <= isa_pkg::HALT;
		for (int i = 0; i < 6; i++) begin
			@(posedge clock);
			in_ready <= ~in_ready; // Must not release HALT
			@(negedge clock);
			compare_value(ctrl, control_pkg::CTRL_IDLE, "ctrl while halted");
		end
		@(posedge clock);
		halt_release <= 1'b1;
		@(posedge clock);
		opcode       <= isa_pkg::NOP;
		halt_release <= 1'b0;
		wait_flag(1'b1, "pc_clear");
		compare_value(ctrl, expected_restart(), "word on HALT release");
		@(negedge clock);
		compare_value(ctrl, expected_word(isa_pkg::NOP), "NOP after HALT");
	endtask

	task automatic restart_from_input();
		@(posedge clock);
		opcode   <= isa_pkg::IN;
		in_ready <= 1'b0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		compare_value(ctrl, control_pkg::CTRL_IDLE, "ctrl stopped in IN");
		@(posedge clock);
		opcode <= isa_pkg::RESET;
		@(posedge clock);
		opcode <= isa_pkg::ADD;
		wait_flag(1'b1, "pc_clear");
		compare_value(ctrl, expected_restart(), "RESET while stopped");
		@(negedge clock);
		compare_value(ctrl, expected_word(isa_pkg::ADD), "ADD after RESET");
		@(posedge clock);
		opcode <= isa_pkg::NOP;
	endtask

	initial begin
		errors       = 0;
		timeouts     = 0;
		lfsr         = 32'hb4a9eff1;
		reset        <= 1'b1;
		opcode       <= isa_pkg::NOP;
		in_ready     <= 1'b0;
		halt_release <= 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		after_reset_idle();
		defined_opcodes();
		undefined_opcodes();
		input_stall();
		halt_release_restart();
		restart_from_input();

		@(negedge clock);
		$display("Value errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+testbench
hdl/isa_pkg.sv
hdl/control_pkg.sv
hdl/opcode_decoder.sv
hdl/run_state_fsm.sv
hdl/control_unit.sv
testbench/tb_control_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_control_unit -f project.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_control_unit 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1
